// ==== mem_system.f ====
src/cache_pkg.sv
src/mem_pkg.sv
src/line_counter.sv
src/cache_array.sv
src/banked_mem.sv
src/cache_ctrl.sv
src/mem_system.sv
test/clk_gen.sv
test/mem_system_tb.sv

// ==== test/mem_system_tb.sv ====
// Reads only addresses it has written, since memory and line data start unknown
`timescale 1ns/1ps
`default_nettype none

module mem_system_tb;

   localparam int mem_latency  = 3;
   localparam int sets         = 2 ** cache_pkg::index_w;
   localparam int num_writes   = 24;
   localparam int num_reads    = 32;
   localparam int num_requests = num_writes + num_reads + 11;  // Plus directed tests

   logic             clk;
   logic             rst_n;
   cache_pkg::word_t addr, data_in, data_out;
   logic             rd, wr, done, cache_hit, err;

   // Reference model of written words and of the tag state
   cache_pkg::word_t            mem_model [cache_pkg::word_t];
   cache_pkg::word_t            written [$];
   logic                        tag_valid [sets];
   logic                        tag_dirty [sets];
   logic [cache_pkg::tag_w-1:0] tag_copy [sets];
   integer                      seed;

   clk_gen #(.period(40)) clk_i (.clk(clk));

   mem_system #(.mem_latency(mem_latency)) dut_i (
      .clk(clk), .rst_n(rst_n), .addr(addr), .data_in(data_in), .rd(rd), .wr(wr),
      .data_out(data_out), .done(done), .cache_hit(cache_hit), .err(err)
   );

   task automatic mismatch(input string what, input logic [31:0] exp_v, input logic [31:0] act_v);
      $display("error: %s expected %h actual %h", what, exp_v, act_v);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic give_up(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic quiet_check(input string test);
      assert (done === 1'b0 && err === 1'b0 && cache_hit === 1'b0)
         else give_up({test, ": done, err or cache_hit high with no request pending"});
   endtask

   // Called at a falling edge, returns at a falling edge
   task automatic access(input string test, input logic r, input logic w,
                         input cache_pkg::word_t a, input cache_pkg::word_t d);
      cache_pkg::addr_u       au;
      logic [7:0]             idx;
      logic                   exp_err;
      logic                   exp_hit;
      int                     exp_cycles;
      int                     cycles;
      au      = cache_pkg::addr_u'(a);
      idx     = au.fields.index;
      exp_err = a[0] | (r & w);
      exp_hit = !exp_err && tag_valid[idx] && (tag_copy[idx] == au.fields.tag);
      if (exp_err || exp_hit) begin
         exp_cycles = 2;  // Sampled, compared, done
      end else begin
         exp_cycles = 2 + cache_pkg::line_words + mem_latency;
         if (tag_valid[idx] && tag_dirty[idx]) exp_cycles += cache_pkg::line_words;
      end
      addr    = a;
      data_in = d;
      rd      = r;
      wr      = w;
      cycles  = 0;
      do begin
         @(negedge clk);
         cycles++;
      end while (done !== 1'b1);
      assert (err === exp_err) else mismatch({test, " err"}, exp_err, err);
      assert (cache_hit === exp_hit) else mismatch({test, " cache_hit"}, exp_hit, cache_hit);
      assert (cycles == exp_cycles) else mismatch({test, " latency"}, exp_cycles, cycles);
      if (r && !exp_err) begin
         assert (data_out === mem_model[a]) else mismatch({test, " data"}, mem_model[a], data_out);
      end
      if (!exp_err) begin
         if (w && !mem_model.exists(a)) written.push_back(a);
         if (w) mem_model[a] = d;
         tag_dirty[idx] = exp_hit ? (tag_dirty[idx] | w) : w;
         tag_valid[idx] = 1'b1;
         tag_copy[idx]  = au.fields.tag;
      end
      rd = 1'b0;
      wr = 1'b0;
      @(negedge clk);
      quiet_check(test);  // Exactly one done pulse
   endtask

   // Done only while a request is held
   assert property (@(negedge clk) disable iff (!rst_n) done |-> (rd || wr))
      else give_up("done pulse with no request pending");

   // Watchdog
   initial begin
      repeat (num_requests * (2 * cache_pkg::line_words + mem_latency + 6) + 100) @(posedge clk);
      give_up("Watchdog expired before all requests completed");
   end

   initial begin
      cache_pkg::addr_u au;
      cache_pkg::addr_u a_addr;
      cache_pkg::addr_u b_addr;
      seed    = 32'h0c2a_f1eb;
      rst_n   = 1'b0;
      addr    = '0;
      data_in = '0;
      rd      = 1'b0;
      wr      = 1'b0;
      for (int i = 0; i < sets; i++) begin
         tag_valid[i] = 1'b0;
         tag_dirty[i] = 1'b0;
      end
      repeat (16) @(negedge clk);
      rst_n = 1'b1;
      repeat (4) begin
         @(negedge clk);
         quiet_check("reset");
      end

      // Few sets, many tags, so dirty evictions are frequent
      for (int i = 0; i < num_writes; i++) begin
         au.flat             = 16'($random(seed));
         au.fields.index     = au.fields.index & 8'h07;
         au.fields.offset[0] = 1'b0;
         access("random write", 1'b0, 1'b1, au.flat, 16'($random(seed)));
      end
      for (int i = 0; i < num_reads; i++) begin
         access("random read", 1'b1, 1'b0, written[$unsigned($random(seed)) % written.size()], '0);
      end

      // Same index, different tags
      a_addr.fields = '{tag: 5'h03, index: 8'h40, offset: 3'h2};
      b_addr.fields = '{tag: 5'h11, index: 8'h40, offset: 3'h6};
      access("eviction", 1'b0, 1'b1, a_addr.flat, 16'h5a3c);
      access("eviction", 1'b0, 1'b1, b_addr.flat, 16'hc3a5);
      access("eviction", 1'b1, 1'b0, a_addr.flat, '0);
      access("eviction", 1'b1, 1'b0, b_addr.flat, '0);

      access("error", 1'b0, 1'b1, a_addr.flat | 16'h1, 16'hdead);
      access("error", 1'b1, 1'b0, b_addr.flat | 16'h1, '0);
      access("error", 1'b1, 1'b1, b_addr.flat, 16'hbeef);
      access("error", 1'b1, 1'b0, b_addr.flat, '0);  // Line untouched, still a hit

      // Clean line made dirty by a write hit must be written back on eviction
      access("write hit", 1'b0, 1'b1, b_addr.flat, 16'h7e81);
      access("write hit", 1'b1, 1'b0, a_addr.flat, '0);
      access("write hit", 1'b1, 1'b0, b_addr.flat, '0);

      $display("Simulation passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== test/clk_gen.sv ====
// Free-running clock starting low, period set by parameter in ns
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
   parameter int period = 40
) (
   output logic clk
);

   initial clk = 1'b0;
   always #(period / 2) clk = ~clk;  // 50 percent duty

endmodule

`default_nettype wire

// ==== src/mem_system.sv ====
// Requester holds addr, data_in and rd or wr until done; memory contents are not reset
`timescale 1ns/1ps
`default_nettype none

module mem_system #(
   parameter int mem_latency = 3
) (
   input  logic             clk,
   input  logic             rst_n,
   input  cache_pkg::word_t addr,
   input  cache_pkg::word_t data_in,
   input  logic             rd,
   input  logic             wr,
   output cache_pkg::word_t data_out,
   output logic             done,
   output logic             cache_hit,
   output logic             err
);

   cache_pkg::addr_u            cpu_addr;
   cache_pkg::addr_u            mem_addr;
   mem_pkg::mem_req_t           mem_req;
   cache_pkg::word_t            mem_rdata;
   cache_pkg::word_t            line_rdata;
   logic [cache_pkg::tag_w-1:0] victim_tag;
   logic [1:0]                  issue_idx;
   logic [1:0]                  return_idx;
   logic [1:0]                  rd_idx;
   logic cache_we, fill_sel, set_dirty, set_valid;
   logic mem_rd, mem_wr, count_clr, issue_en;
   logic hit, dirty, issue_last, return_last, rvalid;

   assign cpu_addr = cache_pkg::addr_u'(addr);

   // Write-back goes to the victim's address, fills to the requested line
   always_comb begin
      mem_addr.fields.tag    = mem_wr ? victim_tag : cpu_addr.fields.tag;
      mem_addr.fields.index  = cpu_addr.fields.index;
      mem_addr.fields.offset = {issue_idx, 1'b0};
   end

   assign mem_req = '{rd: mem_rd, wr: mem_wr, addr: mem_addr, wdata: line_rdata};
   assign rd_idx  = mem_wr ? issue_idx : cpu_addr.fields.offset[2:1];  // Victim word while writing back
   assign data_out = line_rdata;

   cache_ctrl ctrl_i (
      .clk(clk), .rst_n(rst_n), .rd(rd), .wr(wr), .misaligned(addr[0]),
      .hit(hit), .dirty(dirty), .issue_last(issue_last), .return_last(return_last),
      .rvalid(rvalid), .cache_we(cache_we), .fill_sel(fill_sel), .set_dirty(set_dirty),
      .set_valid(set_valid), .mem_rd(mem_rd), .mem_wr(mem_wr), .count_clr(count_clr),
      .issue_en(issue_en), .done(done), .cache_hit(cache_hit), .err(err)
   );

   line_counter count_i (
      .clk(clk), .rst_n(rst_n), .clr(count_clr), .issue_en(issue_en), .rvalid(rvalid),
      .issue_idx(issue_idx), .return_idx(return_idx),
      .issue_last(issue_last), .return_last(return_last)
   );

   cache_array array_i (
      .clk(clk), .rst_n(rst_n), .addr(cpu_addr), .we(cache_we), .fill_sel(fill_sel),
      .set_dirty(set_dirty), .set_valid(set_valid), .rd_idx(rd_idx), .fill_idx(return_idx),
      .fill_data(mem_rdata), .wdata(data_in), .rdata(line_rdata),
      .hit(hit), .dirty(dirty), .victim_tag(victim_tag)
   );

   banked_mem #(.mem_latency(mem_latency)) mem_i (
      .clk(clk), .rst_n(rst_n), .req(mem_req), .rdata(mem_rdata), .rvalid(rvalid)
   );

endmodule

`default_nettype wire

// ==== src/cache_ctrl.sv ====
// Hit or error ends in done two edges after idle sees the request; misses add write-back and fill
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
   input  logic clk,
   input  logic rst_n,
   input  logic rd,
   input  logic wr,
   input  logic misaligned,
   input  logic hit,
   input  logic dirty,
   input  logic issue_last,
   input  logic return_last,
   input  logic rvalid,
   output logic cache_we,
   output logic fill_sel,
   output logic set_dirty,
   output logic set_valid,
   output logic mem_rd,
   output logic mem_wr,
   output logic count_clr,
   output logic issue_en,
   output logic done,
   output logic cache_hit,
   output logic err
);

   typedef enum logic [2:0] {
      idle, compare, write_back, fill_issue, fill_wait, finish
   } state_t;

   state_t state, next_state;
   logic   hit_q;
   logic   err_q;
   logic   req_err;

   assign req_err = misaligned | (rd & wr);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= idle;
         hit_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         state <= next_state;
         if (state == compare) begin  // Result held until finish
            hit_q <= hit & ~req_err;
            err_q <= req_err;
         end
      end
   end

   always_comb begin
      next_state = state;
      cache_we   = 1'b0;
      fill_sel   = 1'b0;
      set_dirty  = 1'b0;
      set_valid  = 1'b0;
      mem_rd     = 1'b0;
      mem_wr     = 1'b0;
      count_clr  = 1'b0;
      issue_en   = 1'b0;
      case (state)
         idle: if (rd | wr) next_state = compare;
         compare: begin
            count_clr = 1'b1;
            if (req_err) begin
               next_state = finish;  // No access on error
            end else if (hit) begin
               cache_we   = wr;
               set_dirty  = wr;
               next_state = finish;
            end else if (dirty) begin
               next_state = write_back;
            end else begin
               next_state = fill_issue;
            end
         end
         write_back: begin
            mem_wr   = 1'b1;  // One victim word per cycle
            issue_en = 1'b1;
            if (issue_last) next_state = fill_issue;
         end
         fill_issue: begin
            mem_rd    = 1'b1;
            issue_en  = 1'b1;
            cache_we  = rvalid;  // Short latency returns overlap issue
            fill_sel  = 1'b1;
            set_dirty = wr;
            if (issue_last) next_state = fill_wait;
         end
         fill_wait: begin
            cache_we  = rvalid;
            fill_sel  = 1'b1;
            set_dirty = wr;      // Write miss merges data_in into the fill
            if (rvalid && return_last) begin
               set_valid  = 1'b1;
               next_state = finish;
            end
         end
         finish:  next_state = idle;
         default: next_state = idle;
      endcase
   end

   assign done      = (state == finish);
   assign cache_hit = done & hit_q;
   assign err       = done & err_q;

endmodule

`default_nettype wire

// ==== src/banked_mem.sv ====
// Fixed read latency of mem_latency cycles, at least 1; bank contents are not reset
`timescale 1ns/1ps
`default_nettype none

module banked_mem #(
   parameter int mem_latency = 3
) (
   input  logic              clk,
   input  logic              rst_n,
   input  mem_pkg::mem_req_t req,
   output cache_pkg::word_t  rdata,
   output logic              rvalid
);

   localparam int bank_w = $clog2(mem_pkg::bank_count);
   localparam int row_w  = 16 - cache_pkg::offset_w;  // 8K words per bank

   cache_pkg::word_t       banks [mem_pkg::bank_count][2 ** row_w];
   cache_pkg::word_t       data_pipe [mem_latency];
   logic [mem_latency-1:0] vld_pipe;
   logic [bank_w-1:0]      sel;
   logic [row_w-1:0]       row;

   // Flat word address: bank from the low word bits, row from the line number
   assign sel = req.addr.flat[bank_w:1];
   assign row = req.addr.flat[15:cache_pkg::offset_w];

   always_ff @(posedge clk) begin
      if (req.wr) banks[sel][row] <= req.wdata;
   end

   // Stage 0 captures the read, the rest only delay it
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         vld_pipe <= '0;
         for (int i = 0; i < mem_latency; i++) begin
            data_pipe[i] <= '0;
         end
      end else begin
         vld_pipe[0]  <= req.rd;
         data_pipe[0] <= banks[sel][row];
         for (int i = 1; i < mem_latency; i++) begin
            vld_pipe[i]  <= vld_pipe[i-1];
            data_pipe[i] <= data_pipe[i-1];
         end
      end
   end

   assign rdata  = data_pipe[mem_latency-1];
   assign rvalid = vld_pipe[mem_latency-1];

endmodule

`default_nettype wire

// ==== src/cache_array.sv ====
// Direct-mapped storage with combinational tag compare and read; line data is not reset
`timescale 1ns/1ps
`default_nettype none

module cache_array (
   input  logic                        clk,
   input  logic                        rst_n,
   input  cache_pkg::addr_u            addr,
   input  logic                        we,
   input  logic                        fill_sel,
   input  logic                        set_dirty,
   input  logic                        set_valid,
   input  logic [1:0]                  rd_idx,
   input  logic [1:0]                  fill_idx,
   input  cache_pkg::word_t            fill_data,
   input  cache_pkg::word_t            wdata,
   output cache_pkg::word_t            rdata,
   output logic                        hit,
   output logic                        dirty,
   output logic [cache_pkg::tag_w-1:0] victim_tag
);

   localparam int sets = 2 ** cache_pkg::index_w;

   cache_pkg::tag_entry_t entries [sets];
   cache_pkg::word_t      lines [sets][cache_pkg::line_words];
   cache_pkg::tag_entry_t entry;
   logic [1:0]            off_idx;
   logic [1:0]            wr_idx;
   cache_pkg::word_t      wr_data;

   assign entry      = entries[addr.fields.index];
   assign off_idx    = addr.fields.offset[2:1];  // Word within the line
   assign hit        = entry.valid && (entry.tag == addr.fields.tag);
   assign dirty      = entry.valid && entry.dirty;
   assign victim_tag = entry.tag;
   assign rdata      = lines[addr.fields.index][rd_idx];

   // A write miss takes data_in in place of the fetched word at its offset
   always_comb begin
      wr_idx = fill_sel ? fill_idx : off_idx;
      if (fill_sel && !(set_dirty && fill_idx == off_idx)) begin
         wr_data = fill_data;
      end else begin
         wr_data = wdata;
      end
   end

   always_ff @(posedge clk) begin
      if (we) lines[addr.fields.index][wr_idx] <= wr_data;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < sets; i++) begin
            entries[i] <= '0;
         end
      end else if (set_valid) begin  // Last word of a fill
         entries[addr.fields.index] <= '{valid: 1'b1, dirty: set_dirty,
                                          tag: addr.fields.tag};
      end else if (we && set_dirty && !fill_sel) begin
         entries[addr.fields.index].dirty <= 1'b1;  // Write hit
      end
   end

endmodule

`default_nettype wire

// ==== src/line_counter.sv ====
// Both counts wrap after one line, so a write-back leaves the issue count at zero for the fill
`timescale 1ns/1ps
`default_nettype none

module line_counter (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       clr,
   input  logic       issue_en,
   input  logic       rvalid,
   output logic [1:0] issue_idx,
   output logic [1:0] return_idx,
   output logic       issue_last,
   output logic       return_last
);

   localparam logic [1:0] last_idx = 2'(cache_pkg::line_words - 1);

   always_ff @(posedge clk) begin
      if (!rst_n || clr) begin
         issue_idx  <= '0;
         return_idx <= '0;
      end else begin
         if (issue_en) issue_idx <= issue_idx + 2'd1;   // Word sent to memory
         if (rvalid) return_idx <= return_idx + 2'd1;   // Word back from memory
      end
   end

   // Reads in flight make these differ during a fill
   assign issue_last  = (issue_idx == last_idx);
   assign return_last = (return_idx == last_idx);

endmodule

`default_nettype wire

// ==== src/mem_pkg.sv ====
// Memory request format for the banked memory, one word per request and rd and wr exclusive
`default_nettype none

package mem_pkg;

   localparam int bank_count = 4;  // Interleaved on word address bits 2:1

   // 34-bit request, built by the top from controller strobes
   typedef struct packed {
      logic              rd;
      logic              wr;
      cache_pkg::addr_u  addr;   // Decoded flat by the memory
      cache_pkg::word_t  wdata;
   } mem_req_t;

endpackage

`default_nettype wire

// ==== src/cache_pkg.sv ====
// Cache geometry is fixed at 16-bit byte addresses, 8-byte lines and 256 direct-mapped sets
`default_nettype none

package cache_pkg;

   localparam int tag_w      = 5;
   localparam int index_w    = 8;
   localparam int offset_w   = 3;  // Byte offset in a line
   localparam int line_words = 4;  // 16-bit words per line, one per bank

   typedef logic [15:0] word_t;

   // Address as the cache sees it
   typedef struct packed {
      logic [tag_w-1:0]    tag;
      logic [index_w-1:0]  index;
      logic [offset_w-1:0] offset;  // Bit 0 is zero for a valid access
   } addr_fields_t;

   // Same word, flat for the memory and split for the cache
   typedef union packed {
      logic [15:0]  flat;
      addr_fields_t fields;
   } addr_u;

   // One entry per set, 7 bits wide
   typedef struct packed {
      logic             valid;
      logic             dirty;
      logic [tag_w-1:0] tag;
   } tag_entry_t;

endpackage

`default_nettype wire
